//--- tests/ifetch_testdata.txt
// Columns, hex: op a b c. 1 mem adr word, 2 tlb vpage ppage exe, 3 expect thread pc word,
// 4 fault thread pc, 5 redirect thread pc, 6 set pc thread pc, 7 run mask mmu,
// 8 tlb invalidate, 9 miss count, 0 end. Words not in the image read as ~adr
1 3000 11112222 0
1 3004 33334444 0
// Identity mapping, cold misses, redirect of thread 0
6 1 100 0
3 0 0 ffffffff
3 0 4 fffffffb
5 0 20 0
3 0 20 ffffffdf
3 0 24 ffffffdb
3 1 100 fffffeff
3 1 104 fffffefb
7 3 0 0
9 6 0 0
// Set 0 eviction by LRU
6 0 200 0
3 0 200 fffffdff
7 1 0 0
6 0 0 0
3 0 0 ffffffff
7 1 0 0
9 8 0 0
6 0 200 0
3 0 200 fffffdff
7 1 0 0
9 8 0 0
// Translation on, no execute page and unmapped page
2 1 3 1
2 2 4 0
6 0 2000 0
6 1 1000 0
4 0 2000 0
5 0 5000 0
4 0 5000 0
3 1 1000 11112222
3 1 1004 33334444
7 3 1 0
9 a 0 0
// Invalidate all, then map again
8 0 0 0
6 1 1000 0
4 1 1000 0
7 2 1 0
2 1 3 1
6 1 1000 0
3 1 1000 11112222
7 2 1 0
9 a 0 0
0 0 0 0

//--- vlog.f
source/ifetch_pkg.sv
source/rr_arbiter.sv
source/sram_1r1w.sv
source/itlb.sv
source/ifetch_tag_stage.sv
source/ifetch_data_stage.sv
source/ifetch_top.sv
tests/tb_ifetch.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench; exit status is the simulation result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ifetch -f vlog.f \
  && ./obj_dir/Vtb_ifetch \
  || exit 1

//--- tests/tb_ifetch.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ifetch;

  localparam int RUN_TIMEOUT = 2000;
  localparam int CMD_WORDS = 256;

  logic clk;
  logic reset;
  logic [1:0] fetch_en;
  logic rollback_en;
  logic rollback_thread;
  logic [31:0] rollback_pc;
  logic tlb_update_en;
  logic [19:0] tlb_update_vpage;
  logic [19:0] tlb_update_ppage;
  logic tlb_update_exe;
  logic tlb_invalidate_all;
  logic mmu_en;
  logic miss_valid;
  logic miss_ready;
  logic [31:0] miss_padr;
  logic miss_thread;
  logic fill_en;
  logic [31:0] fill_padr;
  logic [31:0] fill_word;
  logic fill_thread;
  logic inst_valid;
  logic inst_thread;
  logic [31:0] inst_pc;
  logic [31:0] inst_word;
  logic inst_fault;

  logic [31:0] cmd_mem [0:CMD_WORDS-1];
  logic [31:0] mem_image [logic [31:0]];
  // Bit 65 redirect, bit 64 fault, then pc and word
  logic [65:0] expect_q [2][$];
  logic [15:0] lfsr_state;
  int miss_count;
  int phase;

  ifetch_top u_ifetch_top(
    .clk(clk),
    .reset(reset),
    .fetch_en(fetch_en),
    .rollback_en(rollback_en),
    .rollback_thread(rollback_thread),
    .rollback_pc(rollback_pc),
    .tlb_update_en(tlb_update_en),
    .tlb_update_vpage(tlb_update_vpage),
    .tlb_update_ppage(tlb_update_ppage),
    .tlb_update_exe(tlb_update_exe),
    .tlb_invalidate_all(tlb_invalidate_all),
    .mmu_en(mmu_en),
    .miss_valid(miss_valid),
    .miss_ready(miss_ready),
    .miss_padr(miss_padr),
    .miss_thread(miss_thread),
    .fill_en(fill_en),
    .fill_padr(fill_padr),
    .fill_word(fill_word),
    .fill_thread(fill_thread),
    .inst_valid(inst_valid),
    .inst_thread(inst_thread),
    .inst_pc(inst_pc),
    .inst_word(inst_word),
    .inst_fault(inst_fault));

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
    input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  // Galois LFSR with taps for a 16 bit maximal sequence
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    if (state[0])
      return (state >> 1) ^ 16'hB400;
    else
      return state >> 1;
  endfunction

  task automatic draw_bits(input int nbits, output int value);
    value = 0;
    for (int i = 0; i < nbits; i++)
    begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Words missing from the image read back as the inverted address
  function automatic logic [31:0] image_word(input logic [31:0] adr);
    if (mem_image.exists(adr))
      return mem_image[adr];
    else
      return ~adr;
  endfunction

  // A miss asks for the word its thread is expected to deliver next
  task automatic check_miss_request();
    int t;
    t = int'(miss_thread);
    if (expect_q[t].size() == 0)
      fail_run($sformatf("Miss request from thread %0d with no output left to fetch", t));
    else
      check_value($sformatf("phase %0d thread %0d miss padr %h word", phase, t, miss_padr),
        expect_q[t][0][31:0], image_word(miss_padr));
  endtask

  // Match one output against its thread's list, then redirect or stop that thread
  task automatic watch_output();
    logic [65:0] head;
    int t;
    if (inst_valid)
    begin
      t = int'(inst_thread);
      if (expect_q[t].size() == 0)
        fail_run($sformatf("Unexpected output from thread %0d at pc %h", t, inst_pc));
      else
      begin
        head = expect_q[t].pop_front();
        check_value($sformatf("phase %0d thread %0d pc", phase, t), head[63:32], inst_pc);
        check_value($sformatf("phase %0d thread %0d pc %h fault", phase, t, inst_pc),
          {31'b0, head[64]}, {31'b0, inst_fault});
        if (!head[64])
          check_value($sformatf("phase %0d thread %0d pc %h word", phase, t, inst_pc),
            head[31:0], inst_word);
        if (expect_q[t].size() != 0 && expect_q[t][0][65])
        begin
          head = expect_q[t].pop_front();
          rollback_en = 1'b1;
          rollback_thread = t[0];
          rollback_pc = head[63:32];
        end
        else if (expect_q[t].size() == 0)
        begin
          // Last item seen, so squash whatever this thread has in flight
          fetch_en[t] = 1'b0;
          rollback_en = 1'b1;
          rollback_thread = t[0];
          rollback_pc = inst_pc + 32'd4;
        end
      end
    end
  endtask

  task automatic step_cycle();
    @(negedge clk);
    rollback_en = 1'b0;
    tlb_update_en = 1'b0;
    tlb_invalidate_all = 1'b0;
    watch_output();
  endtask

  task automatic run_phase(input logic [1:0] mask, input logic mmu);
    int cycles;
    phase++;
    fetch_en = mask;
    mmu_en = mmu;
    cycles = 0;
    while (expect_q[0].size() != 0 || expect_q[1].size() != 0)
    begin
      if (cycles > RUN_TIMEOUT)
        fail_run($sformatf("Phase %0d timed out waiting for expected outputs", phase));
      else
      begin
        step_cycle();
        cycles++;
      end
    end
    fetch_en = '0;
    // Quiet cycles catch stale items left in the pipeline
    repeat (4) step_cycle();
  endtask

  // L2 model with random accept and fill latency
  initial
  begin
    int state;
    int delay;
    logic [31:0] req_padr;
    logic req_thread;
    miss_ready = 1'b0;
    fill_en = 1'b0;
    fill_padr = '0;
    fill_word = '0;
    fill_thread = 1'b0;
    miss_count = 0;
    lfsr_state = 16'd26;
    state = 0;
    delay = 0;
    forever
    begin
      @(negedge clk);
      miss_ready = 1'b0;
      fill_en = 1'b0;
      if (!reset)
      begin
        case (state)
          0:
            if (miss_valid)
            begin
              draw_bits(2, delay);
              state = 1;
            end
          1:
            if (delay == 0)
            begin
              check_miss_request();
              req_padr = miss_padr;
              req_thread = miss_thread;
              miss_ready = 1'b1;
              state = 2;
            end
            else
              delay--;
          2:
          begin
            miss_count++;
            draw_bits(2, delay);
            state = 3;
          end
          default:
            if (delay == 0)
            begin
              fill_en = 1'b1;
              fill_padr = req_padr;
              fill_word = image_word(req_padr);
              fill_thread = req_thread;
              state = 0;
            end
            else
              delay--;
        endcase
      end
    end
  end

  initial
  begin
    int idx;
    logic [31:0] op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic done;
    reset = 1'b1;
    fetch_en = '0;
    rollback_en = 1'b0;
    rollback_thread = 1'b0;
    rollback_pc = '0;
    tlb_update_en = 1'b0;
    tlb_update_vpage = '0;
    tlb_update_ppage = '0;
    tlb_update_exe = 1'b0;
    tlb_invalidate_all = 1'b0;
    mmu_en = 1'b0;
    phase = 0;
    for (int i = 0; i < CMD_WORDS; i++)
      cmd_mem[i] = '0;
    $readmemh("tests/ifetch_testdata.txt", cmd_mem);
    repeat (4) @(negedge clk);
    reset = 1'b0;

    idx = 0;
    done = 1'b0;
    while (!done && idx < CMD_WORDS)
    begin
      op = cmd_mem[idx];
      a = cmd_mem[idx + 1];
      b = cmd_mem[idx + 2];
      c = cmd_mem[idx + 3];
      idx += 4;
      case (op)
        0: done = 1'b1;
        1: mem_image[a] = b;
        2:
        begin
          step_cycle();
          tlb_update_en = 1'b1;
          tlb_update_vpage = a[19:0];
          tlb_update_ppage = b[19:0];
          tlb_update_exe = c[0];
          step_cycle();
        end
        3: expect_q[a[0]].push_back({2'b00, b, c});
        4: expect_q[a[0]].push_back({2'b01, b, 32'h0});
        5: expect_q[a[0]].push_back({2'b10, b, 32'h0});
        6:
        begin
          step_cycle();
          rollback_en = 1'b1;
          rollback_thread = a[0];
          rollback_pc = b;
          step_cycle();
        end
        7: run_phase(a[1:0], b[0]);
        8:
        begin
          step_cycle();
          tlb_invalidate_all = 1'b1;
          step_cycle();
        end
        9: check_value($sformatf("phase %0d miss count", phase), a, miss_count);
        default: fail_run($sformatf("Unknown command %h in the data file", op));
      endcase
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/ifetch_top.sv
`timescale 1ns/10ps
`default_nettype none

module ifetch_top
  (input wire clk,
  input wire reset,
  input wire ifetch_pkg::thread_map_t fetch_en,
  input wire rollback_en,
  input wire ifetch_pkg::thread_idx_t rollback_thread,
  input wire ifetch_pkg::ifetch_adr_t rollback_pc,
  input wire tlb_update_en,
  input wire ifetch_pkg::page_idx_t tlb_update_vpage,
  input wire ifetch_pkg::page_idx_t tlb_update_ppage,
  input wire tlb_update_exe,
  input wire tlb_invalidate_all,
  input wire mmu_en,
  output logic miss_valid,
  input wire miss_ready,
  output ifetch_pkg::ifetch_adr_t miss_padr,
  output ifetch_pkg::thread_idx_t miss_thread,
  input wire fill_en,
  input wire ifetch_pkg::ifetch_adr_t fill_padr,
  input wire [31:0] fill_word,
  input wire ifetch_pkg::thread_idx_t fill_thread,
  output logic inst_valid,
  output ifetch_pkg::thread_idx_t inst_thread,
  output ifetch_pkg::ifetch_adr_t inst_pc,
  output logic [31:0] inst_word,
  output logic inst_fault);

  logic ift_valid_req;
  ifetch_pkg::thread_idx_t ift_thread;
  ifetch_pkg::ifetch_adr_t ift_pc_vadr;
  ifetch_pkg::ifetch_adr_t ift_pc_padr;
  logic ift_tlb_hit;
  logic ift_tlb_exe;
  ifetch_pkg::cache_tag_t ift_tags [ifetch_pkg::WAYS];
  logic [ifetch_pkg::WAYS-1:0] ift_line_valid;
  ifetch_pkg::set_idx_t ift_set;
  ifetch_pkg::way_idx_t fill_way;
  logic ifd_miss;
  ifetch_pkg::thread_idx_t ifd_miss_thread;
  logic ifd_lru_update_en;
  ifetch_pkg::way_idx_t ifd_lru_way;
  logic ifd_miss_pending;

  ifetch_tag_stage u_ifetch_tag_stage(
    .clk(clk),
    .reset(reset),
    .fetch_en(fetch_en),
    .rollback_en(rollback_en),
    .rollback_thread(rollback_thread),
    .rollback_pc(rollback_pc),
    .tlb_update_en(tlb_update_en),
    .tlb_update_vpage(tlb_update_vpage),
    .tlb_update_ppage(tlb_update_ppage),
    .tlb_update_exe(tlb_update_exe),
    .tlb_invalidate_all(tlb_invalidate_all),
    .mmu_en(mmu_en),
    .fill_en(fill_en),
    .fill_padr(fill_padr),
    .fill_thread(fill_thread),
    .ifd_miss(ifd_miss),
    .ifd_miss_thread(ifd_miss_thread),
    .ifd_lru_update_en(ifd_lru_update_en),
    .ifd_lru_way(ifd_lru_way),
    .ifd_miss_pending(ifd_miss_pending),
    .ift_valid_req(ift_valid_req),
    .ift_thread(ift_thread),
    .ift_pc_vadr(ift_pc_vadr),
    .ift_pc_padr(ift_pc_padr),
    .ift_tlb_hit(ift_tlb_hit),
    .ift_tlb_exe(ift_tlb_exe),
    .ift_tags(ift_tags),
    .ift_line_valid(ift_line_valid),
    .ift_set(ift_set),
    .fill_way(fill_way));

  ifetch_data_stage u_ifetch_data_stage(
    .clk(clk),
    .reset(reset),
    .ift_valid_req(ift_valid_req),
    .ift_thread(ift_thread),
    .ift_pc_vadr(ift_pc_vadr),
    .ift_pc_padr(ift_pc_padr),
    .ift_tlb_hit(ift_tlb_hit),
    .ift_tlb_exe(ift_tlb_exe),
    .ift_tags(ift_tags),
    .ift_line_valid(ift_line_valid),
    .ift_set(ift_set),
    .fill_way(fill_way),
    .fill_en(fill_en),
    .fill_padr(fill_padr),
    .fill_word(fill_word),
    .rollback_en(rollback_en),
    .rollback_thread(rollback_thread),
    .miss_ready(miss_ready),
    .ifd_miss(ifd_miss),
    .ifd_miss_thread(ifd_miss_thread),
    .ifd_lru_update_en(ifd_lru_update_en),
    .ifd_lru_way(ifd_lru_way),
    .ifd_miss_pending(ifd_miss_pending),
    .miss_valid(miss_valid),
    .miss_padr(miss_padr),
    .miss_thread(miss_thread),
    .inst_valid(inst_valid),
    .inst_thread(inst_thread),
    .inst_pc(inst_pc),
    .inst_word(inst_word),
    .inst_fault(inst_fault));

endmodule

`default_nettype wire

//--- source/ifetch_data_stage.sv
`timescale 1ns/10ps
`default_nettype none

module ifetch_data_stage
  (input wire clk,
  input wire reset,

  // From the tag stage
  input wire ift_valid_req,
  input wire ifetch_pkg::thread_idx_t ift_thread,
  input wire ifetch_pkg::ifetch_adr_t ift_pc_vadr,
  input wire ifetch_pkg::ifetch_adr_t ift_pc_padr,
  input wire ift_tlb_hit,
  input wire ift_tlb_exe,
  input wire ifetch_pkg::cache_tag_t ift_tags [ifetch_pkg::WAYS],
  input wire [ifetch_pkg::WAYS-1:0] ift_line_valid,
  input wire ifetch_pkg::set_idx_t ift_set,
  input wire ifetch_pkg::way_idx_t fill_way,

  // Fill from the L2 and rollback
  input wire fill_en,
  input wire ifetch_pkg::ifetch_adr_t fill_padr,
  input wire [31:0] fill_word,
  input wire rollback_en,
  input wire ifetch_pkg::thread_idx_t rollback_thread,
  input wire miss_ready,

  // To the tag stage
  output logic ifd_miss,
  output ifetch_pkg::thread_idx_t ifd_miss_thread,
  output logic ifd_lru_update_en,
  output ifetch_pkg::way_idx_t ifd_lru_way,
  output logic ifd_miss_pending,

  // Miss request to the L2
  output logic miss_valid,
  output ifetch_pkg::ifetch_adr_t miss_padr,
  output ifetch_pkg::thread_idx_t miss_thread,

  // Instruction output
  output logic inst_valid,
  output ifetch_pkg::thread_idx_t inst_thread,
  output ifetch_pkg::ifetch_adr_t inst_pc,
  output logic [31:0] inst_word,
  output logic inst_fault);

  logic [ifetch_pkg::WAYS-1:0] hit_oh;
  ifetch_pkg::way_idx_t hit_way;
  ifetch_pkg::way_idx_t inst_way;
  logic [31:0] way_word [ifetch_pkg::WAYS];
  logic item_valid;
  logic translated;
  logic cache_hit;
  logic miss_outstanding;

  // Rollback squashes the item of that thread sitting in this stage
  assign item_valid = ift_valid_req && !(rollback_en && rollback_thread == ift_thread);
  assign translated = ift_tlb_hit && ift_tlb_exe;

  always_comb
  begin
    hit_way = '0;
    for (int w = 0; w < ifetch_pkg::WAYS; w++)
    begin
      hit_oh[w] = ift_line_valid[w] && ift_tags[w] == ift_pc_padr.cache.tag;
      if (hit_oh[w])
        hit_way = ifetch_pkg::way_idx_t'(w);
    end
  end

  assign cache_hit = |hit_oh;

  // Faulting fetches never go to the L2
  assign ifd_miss = item_valid && translated && !cache_hit;
  assign ifd_miss_thread = ift_thread;
  assign ifd_lru_update_en = item_valid && translated && cache_hit;
  assign ifd_lru_way = hit_way;

  // Fetch stays off from the miss decision until its fill lands
  assign ifd_miss_pending = ifd_miss || miss_valid || miss_outstanding;

  // Data is read with the set while the tags are compared
  for (genvar w = 0; w < ifetch_pkg::WAYS; w++)
  begin : data_way_gen
    sram_1r1w #(
      .DATA_WIDTH(32),
      .SIZE(ifetch_pkg::SETS)
    ) u_data_sram(
      .clk(clk),
      .read_en(ift_valid_req),
      .read_adr(ift_set),
      .read_data(way_word[w]),
      .write_en(fill_en && fill_way == ifetch_pkg::way_idx_t'(w)),
      .write_adr(fill_padr.cache.set),
      .write_data(fill_word));
  end

  assign inst_word = way_word[inst_way];

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
      inst_valid <= 1'b0;
    else
      inst_valid <= item_valid && (!translated || cache_hit);
  end

  always_ff @(posedge clk)
  begin
    if (ift_valid_req)
    begin
      inst_thread <= ift_thread;
      inst_pc <= ift_pc_vadr;
      inst_fault <= !translated;
      inst_way <= hit_way;
    end
  end

  // Request holds until accepted, then waits for the fill
  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      miss_valid <= 1'b0;
      miss_outstanding <= 1'b0;
    end
    else
    begin
      if (ifd_miss)
        miss_valid <= 1'b1;
      else if (miss_ready)
        miss_valid <= 1'b0;

      if (miss_valid && miss_ready)
        miss_outstanding <= 1'b1;
      else if (fill_en)
        miss_outstanding <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ifd_miss)
    begin
      miss_padr <= ift_pc_padr;
      miss_thread <= ift_thread;
    end
  end

  one_way_hit: assert property (@(posedge clk) disable iff (reset)
    ift_valid_req |-> $onehot0(hit_oh))
    else $error("line resident in more than one way");

  miss_held: assert property (@(posedge clk) disable iff (reset)
    miss_valid && !miss_ready
      |=> miss_valid && $stable(miss_padr) && $stable(miss_thread))
    else $error("miss request changed before it was accepted");

endmodule

`default_nettype wire

//--- source/ifetch_tag_stage.sv
`timescale 1ns/10ps
`default_nettype none

module ifetch_tag_stage
  #(parameter logic [31:0] RESET_PC = 32'h0)
  (input wire clk,
  input wire reset,

  // Thread control
  input wire ifetch_pkg::thread_map_t fetch_en,
  input wire rollback_en,
  input wire ifetch_pkg::thread_idx_t rollback_thread,
  input wire ifetch_pkg::ifetch_adr_t rollback_pc,

  // TLB maintenance and translation
  input wire tlb_update_en,
  input wire ifetch_pkg::page_idx_t tlb_update_vpage,
  input wire ifetch_pkg::page_idx_t tlb_update_ppage,
  input wire tlb_update_exe,
  input wire tlb_invalidate_all,
  input wire mmu_en,

  // Fill from the L2
  input wire fill_en,
  input wire ifetch_pkg::ifetch_adr_t fill_padr,
  input wire ifetch_pkg::thread_idx_t fill_thread,

  // From the data stage
  input wire ifd_miss,
  input wire ifetch_pkg::thread_idx_t ifd_miss_thread,
  input wire ifd_lru_update_en,
  input wire ifetch_pkg::way_idx_t ifd_lru_way,
  input wire ifd_miss_pending,

  // To the data stage
  output logic ift_valid_req,
  output ifetch_pkg::thread_idx_t ift_thread,
  output ifetch_pkg::ifetch_adr_t ift_pc_vadr,
  output ifetch_pkg::ifetch_adr_t ift_pc_padr,
  output logic ift_tlb_hit,
  output logic ift_tlb_exe,
  output ifetch_pkg::cache_tag_t ift_tags [ifetch_pkg::WAYS],
  output logic [ifetch_pkg::WAYS-1:0] ift_line_valid,
  output ifetch_pkg::set_idx_t ift_set,
  output ifetch_pkg::way_idx_t fill_way);

  ifetch_pkg::ifetch_adr_t pc [ifetch_pkg::THREADS];
  ifetch_pkg::ifetch_adr_t pc_to_fetch;
  ifetch_pkg::thread_map_t can_fetch;
  ifetch_pkg::thread_map_t selected_oh;
  ifetch_pkg::thread_idx_t selected_thread;
  ifetch_pkg::thread_map_t wait_threads;
  ifetch_pkg::thread_map_t miss_oh;
  ifetch_pkg::thread_map_t wake_oh;
  logic cache_fetch_en;
  logic rollback_selected;
  logic request_mmu_en;
  logic tlb_hit;
  logic tlb_exe;
  ifetch_pkg::page_idx_t tlb_ppage;
  logic [ifetch_pkg::WAYS-1:0] line_valid [ifetch_pkg::SETS];
  ifetch_pkg::way_idx_t lru [ifetch_pkg::SETS];

  // Threads asleep on a miss are skipped until their fill returns
  assign can_fetch = fetch_en & ~wait_threads;

  // The TLB port is busy during maintenance, and only one miss may be in flight
  assign cache_fetch_en = |can_fetch && !tlb_update_en && !tlb_invalidate_all
    && !ifd_miss_pending;

  rr_arbiter u_thread_arbiter(
    .clk(clk),
    .reset(reset),
    .request(can_fetch),
    .update(cache_fetch_en),
    .grant_oh(selected_oh));

  always_comb
  begin
    selected_thread = '0;
    for (int t = 0; t < ifetch_pkg::THREADS; t++)
    begin
      if (selected_oh[t])
        selected_thread = ifetch_pkg::thread_idx_t'(t);
    end
  end

  assign pc_to_fetch = pc[selected_thread];
  assign rollback_selected = rollback_en && rollback_thread == selected_thread;

  always_comb
  begin
    miss_oh = '0;
    wake_oh = '0;
    miss_oh[ifd_miss_thread] = ifd_miss;
    wake_oh[fill_thread] = fill_en;
  end

  // Rollback wins over miss restore, which wins over the normal step
  for (genvar t = 0; t < ifetch_pkg::THREADS; t++)
  begin : pc_gen
    always_ff @(posedge clk, posedge reset)
    begin
      if (reset)
        pc[t] <= RESET_PC;
      else if (rollback_en && rollback_thread == ifetch_pkg::thread_idx_t'(t))
        pc[t] <= rollback_pc;
      else if (miss_oh[t])
        pc[t] <= ift_pc_vadr;
      else if (cache_fetch_en && selected_oh[t])
        pc[t] <= ifetch_pkg::ifetch_adr_t'(pc[t] + 32'd4);
    end
  end

  // A rolled back thread still sleeps until its outstanding fill arrives
  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      wait_threads <= '0;
      ift_valid_req <= 1'b0;
    end
    else
    begin
      wait_threads <= (wait_threads | miss_oh) & ~wake_oh;
      ift_valid_req <= cache_fetch_en && !rollback_selected;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cache_fetch_en)
    begin
      ift_thread <= selected_thread;
      ift_pc_vadr <= pc_to_fetch;
      request_mmu_en <= mmu_en;
    end
  end

  // Tag memories, written with the fill address into the LRU way
  for (genvar w = 0; w < ifetch_pkg::WAYS; w++)
  begin : tag_way_gen
    sram_1r1w #(
      .DATA_WIDTH($bits(ifetch_pkg::cache_tag_t)),
      .SIZE(ifetch_pkg::SETS)
    ) u_tag_sram(
      .clk(clk),
      .read_en(cache_fetch_en),
      .read_adr(pc_to_fetch.cache.set),
      .read_data(ift_tags[w]),
      .write_en(fill_en && fill_way == ifetch_pkg::way_idx_t'(w)),
      .write_adr(fill_padr.cache.set),
      .write_data(fill_padr.cache.tag));
  end

  // Valid bits live in flops so reset can clear the whole cache at once
  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < ifetch_pkg::SETS; s++)
        line_valid[s] <= '0;
    end
    else if (fill_en)
      line_valid[fill_padr.cache.set][fill_way] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (cache_fetch_en)
    begin
      ift_line_valid <= line_valid[pc_to_fetch.cache.set];
      // Line being filled this cycle
      if (fill_en && fill_padr.cache.set == pc_to_fetch.cache.set)
        ift_line_valid[fill_way] <= 1'b1;
    end
  end

  // One bit per set names the least recently used way
  assign fill_way = lru[fill_padr.cache.set];

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < ifetch_pkg::SETS; s++)
        lru[s] <= '0;
    end
    else if (fill_en)
      lru[fill_padr.cache.set] <= ~fill_way;
    else if (ifd_lru_update_en)
      lru[ift_set] <= ~ifd_lru_way;
  end

  itlb u_itlb(
    .clk(clk),
    .reset(reset),
    .lookup_en(cache_fetch_en),
    .lookup_vpage(pc_to_fetch.page.page),
    .update_en(tlb_update_en),
    .update_vpage(tlb_update_vpage),
    .update_ppage(tlb_update_ppage),
    .update_exe(tlb_update_exe),
    .invalidate_all(tlb_invalidate_all),
    .lookup_hit(tlb_hit),
    .lookup_ppage(tlb_ppage),
    .lookup_exe(tlb_exe));

  // Identity mapping with translation off
  always_comb
  begin
    ift_pc_padr.page.offset = ift_pc_vadr.page.offset;
    if (request_mmu_en)
    begin
      ift_tlb_hit = tlb_hit;
      ift_tlb_exe = tlb_exe;
      ift_pc_padr.page.page = tlb_ppage;
    end
    else
    begin
      ift_tlb_hit = 1'b1;
      ift_tlb_exe = 1'b1;
      ift_pc_padr.page.page = ift_pc_vadr.page.page;
    end
  end

  // Set bits sit inside the page offset, so virtual and physical sets agree
  assign ift_set = ift_pc_vadr.cache.set;

endmodule

`default_nettype wire

//--- source/itlb.sv
`timescale 1ns/10ps
`default_nettype none

// Fully associative instruction TLB with one cycle of lookup latency
module itlb
  (input wire clk,
  input wire reset,
  input wire lookup_en,
  input wire ifetch_pkg::page_idx_t lookup_vpage,
  input wire update_en,
  input wire ifetch_pkg::page_idx_t update_vpage,
  input wire ifetch_pkg::page_idx_t update_ppage,
  input wire update_exe,
  input wire invalidate_all,
  output logic lookup_hit,
  output ifetch_pkg::page_idx_t lookup_ppage,
  output logic lookup_exe);

  logic [ifetch_pkg::TLB_ENTRIES-1:0] entry_valid;
  logic [ifetch_pkg::TLB_ENTRIES-1:0] entry_exe;
  ifetch_pkg::page_idx_t entry_vpage [ifetch_pkg::TLB_ENTRIES];
  ifetch_pkg::page_idx_t entry_ppage [ifetch_pkg::TLB_ENTRIES];
  logic [ifetch_pkg::TLB_ENTRIES-1:0] lookup_match;
  logic [ifetch_pkg::TLB_ENTRIES-1:0] update_match;
  logic [$clog2(ifetch_pkg::TLB_ENTRIES)-1:0] victim;
  logic [$clog2(ifetch_pkg::TLB_ENTRIES)-1:0] update_idx;
  ifetch_pkg::page_idx_t hit_ppage;
  logic hit_exe;

  always_comb
  begin
    hit_ppage = '0;
    hit_exe = 1'b0;
    update_idx = victim;
    for (int e = 0; e < ifetch_pkg::TLB_ENTRIES; e++)
    begin
      lookup_match[e] = entry_valid[e] && entry_vpage[e] == lookup_vpage;
      update_match[e] = entry_valid[e] && entry_vpage[e] == update_vpage;
      if (lookup_match[e])
      begin
        hit_ppage = entry_ppage[e];
        hit_exe = entry_exe[e];
      end

      // Rewrite an existing mapping in place
      if (update_match[e])
        update_idx = e[$clog2(ifetch_pkg::TLB_ENTRIES)-1:0];
    end
  end

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      entry_valid <= '0;
      victim <= '0;
    end
    else if (invalidate_all)
      entry_valid <= '0;
    else if (update_en)
    begin
      entry_valid[update_idx] <= 1'b1;
      if (update_match == '0)
        victim <= victim + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (update_en)
    begin
      entry_vpage[update_idx] <= update_vpage;
      entry_ppage[update_idx] <= update_ppage;
      entry_exe[update_idx] <= update_exe;
    end
  end

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      lookup_hit <= 1'b0;
      lookup_exe <= 1'b0;
    end
    else if (lookup_en)
    begin
      lookup_hit <= |lookup_match;
      lookup_exe <= hit_exe;
    end
  end

  always_ff @(posedge clk)
  begin
    if (lookup_en)
      lookup_ppage <= hit_ppage;
  end

  unique_match: assert property (@(posedge clk) disable iff (reset)
    lookup_en |-> $onehot0(lookup_match))
    else $error("itlb has more than one entry for a page");

endmodule

`default_nettype wire

//--- source/sram_1r1w.sv
`timescale 1ns/10ps
`default_nettype none

module sram_1r1w
  #(parameter int DATA_WIDTH = 32,
  parameter int SIZE = 16)
  (input wire clk,
  input wire read_en,
  input wire [$clog2(SIZE)-1:0] read_adr,
  output logic [DATA_WIDTH-1:0] read_data,
  input wire write_en,
  input wire [$clog2(SIZE)-1:0] write_adr,
  input wire [DATA_WIDTH-1:0] write_data);

  logic [DATA_WIDTH-1:0] mem [SIZE];

  always_ff @(posedge clk)
  begin
    if (write_en)
      mem[write_adr] <= write_data;

    // Read output holds while read_en is low
    if (read_en)
    begin
      if (write_en && write_adr == read_adr)
        read_data <= write_data;
      else
        read_data <= mem[read_adr];
    end
  end

endmodule

`default_nettype wire

//--- source/rr_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter
  (input wire clk,
  input wire reset,
  input wire ifetch_pkg::thread_map_t request,
  input wire update,
  output ifetch_pkg::thread_map_t grant_oh);

  ifetch_pkg::thread_idx_t last_winner;
  ifetch_pkg::thread_idx_t grant_idx;

  // Scan the requesters starting just after the last winner
  always_comb
  begin
    int candidate;
    grant_oh = '0;
    grant_idx = last_winner;
    for (int step = 1; step <= ifetch_pkg::THREADS; step++)
    begin
      candidate = (int'(last_winner) + step) % ifetch_pkg::THREADS;
      if (request[candidate] && grant_oh == '0)
      begin
        grant_oh[candidate] = 1'b1;
        grant_idx = ifetch_pkg::thread_idx_t'(candidate);
      end
    end
  end

  // Start from the top so thread 0 wins first
  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
      last_winner <= ifetch_pkg::thread_idx_t'(ifetch_pkg::THREADS - 1);
    else if (update)
      last_winner <= grant_idx;
  end

  grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant_oh))
    else $error("rr_arbiter granted more than one thread");

endmodule

`default_nettype wire

//--- source/ifetch_pkg.sv
`default_nettype none

package ifetch_pkg;

  localparam int THREADS = 2;
  localparam int WAYS = 2;
  localparam int SETS = 16;
  localparam int TLB_ENTRIES = 4;
  localparam int PAGE_BITS = 20;

  typedef logic [$clog2(THREADS)-1:0] thread_idx_t;
  typedef logic [THREADS-1:0] thread_map_t;
  typedef logic [$clog2(SETS)-1:0] set_idx_t;
  typedef logic [$clog2(WAYS)-1:0] way_idx_t;

  // One word per line, so only the byte offset sits below the set index
  typedef logic [32-$clog2(SETS)-3:0] cache_tag_t;
  typedef logic [PAGE_BITS-1:0] page_idx_t;

  // Same fetch address seen by the cache and by the TLB
  typedef union packed {
    struct packed {
      cache_tag_t tag;
      set_idx_t set;
      logic [1:0] offset;
    } cache;
    struct packed {
      page_idx_t page;
      logic [31-PAGE_BITS:0] offset;
    } page;
  } ifetch_adr_t;

endpackage

`default_nettype wire
